// File: logic/rob_pkg.sv
// Reorder buffer package
// Sizes of the buffer and its buses, the opcode and entry state encodings,
// and the packed structs that carry dispatch, result bus, LSU acknowledge
// and entry contents between the blocks
`default_nettype none

package rob_pkg;

    // Buffer depth and tag width go together, eight slots need a 3 bit tag
    localparam int ROB_DEPTH = 8;
    localparam int ROB_IDX_W = 3;
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int RAT_IDX_W = 5;
    // Number of result buses that can complete ops in one cycle
    localparam int CDB_DEPTH = 2;

    // Kind of op held in an entry
    // OP_JL writes its jump target into pc and keeps the link address in data
    typedef enum logic [2:0] {
        OP_ALU = 3'd0,
        OP_BR  = 3'd1,
        OP_JL  = 3'd2,
        OP_LD  = 3'd3,
        OP_ST  = 3'd4
    } op_t;

    // Entry life cycle, loads and stores pass through LSU_PENDING
    typedef enum logic [1:0] {
        ST_INVALID     = 2'b00,
        ST_PENDING     = 2'b01,
        ST_LSU_PENDING = 2'b10,
        ST_RETIRABLE   = 2'b11
    } entry_state_t;

    // Op written at the tail, data is whatever is known at dispatch time
    typedef struct packed {
        op_t                  op;
        logic [ADDR_W-1:0]    pc;
        logic [RAT_IDX_W-1:0] rdst;
        logic [DATA_W-1:0]    data;
    } dispatch_t;

    // One result bus write
    typedef struct packed {
        logic                 en;
        logic                 redirect;
        logic [ROB_IDX_W-1:0] tag;
        logic [DATA_W-1:0]    data;
    } cdb_t;

    // Acknowledge from the load queue or store queue for the head op
    typedef struct packed {
        logic lq_ack;
        logic sq_ack;
        logic misspeculated;
    } lsu_ack_t;

    // Visible entry contents, also the retire payload
    typedef struct packed {
        logic                 redirect;
        op_t                  op;
        logic [ADDR_W-1:0]    pc;
        logic [RAT_IDX_W-1:0] rdst;
        logic [DATA_W-1:0]    data;
    } entry_t;

endpackage

`default_nettype wire

// File: logic/rob_entry.sv
// Reorder buffer slot
// Holds one op from dispatch to retire. Tracks its state, captures results
// from the result buses by tag and waits for the LSU acknowledge on loads
// and stores before it can retire
`default_nettype none

module rob_entry #(
    parameter int ENTRY_TAG = 0
) (
    input  logic                  clk,
    input  logic                  i_reset,
    input  logic                  i_flush,
    input  logic                  i_dispatch_en,
    input  rob_pkg::dispatch_t    i_dispatch,
    input  rob_pkg::cdb_t         i_cdb [0:rob_pkg::CDB_DEPTH-1],
    input  rob_pkg::lsu_ack_t     i_lsu_ack,
    input  logic                  i_lsu_ack_sel,
    input  logic                  i_retire_en,
    output logic                  o_retirable,
    output logic                  o_lsu_pending,
    output rob_pkg::entry_t       o_entry
);

    logic [rob_pkg::ROB_IDX_W-1:0] entry_tag;
    rob_pkg::entry_state_t         state_r;
    rob_pkg::entry_state_t         state_nxt;
    rob_pkg::entry_t               entry_r;
    rob_pkg::entry_t               entry_nxt;
    logic                          is_lsu_op;
    logic                          lsu_pending;
    logic                          ld_ack;
    logic                          st_ack;
    logic [rob_pkg::CDB_DEPTH-1:0] cdb_match;
    logic                          cdb_hit;

    // The slot index doubles as the tag handed out at dispatch
    assign entry_tag = ENTRY_TAG[rob_pkg::ROB_IDX_W-1:0];

    assign is_lsu_op   = (entry_r.op == rob_pkg::OP_LD) || (entry_r.op == rob_pkg::OP_ST);
    assign lsu_pending = (state_r == rob_pkg::ST_LSU_PENDING);

    // The acknowledge only counts when it is steered here and its kind fits the op
    assign ld_ack = lsu_pending && i_lsu_ack_sel && (entry_r.op == rob_pkg::OP_LD)
                    && i_lsu_ack.lq_ack;
    assign st_ack = lsu_pending && i_lsu_ack_sel && (entry_r.op == rob_pkg::OP_ST)
                    && i_lsu_ack.sq_ack;

    // Only a pending op listens to the result buses
    always_comb begin
        for (int k = 0; k < rob_pkg::CDB_DEPTH; k++) begin
            cdb_match[k] = i_cdb[k].en && (i_cdb[k].tag == entry_tag)
                           && (state_r == rob_pkg::ST_PENDING);
        end
    end

    assign cdb_hit = |cdb_match;

    // Payload update, later assignments win
    // A load acknowledge replaces redirect with the misspeculation report
    always_comb begin
        entry_nxt = entry_r;
        if (ld_ack) begin
            entry_nxt.redirect = i_lsu_ack.misspeculated;
        end
        // Higher numbered buses take priority when two of them hit
        for (int k = 0; k < rob_pkg::CDB_DEPTH; k++) begin
            if (cdb_match[k]) begin
                entry_nxt.redirect = i_cdb[k].redirect;
                // Jumps deliver a target address, which goes into pc
                if (entry_r.op == rob_pkg::OP_JL) begin
                    entry_nxt.pc = i_cdb[k].data;
                end else begin
                    entry_nxt.data = i_cdb[k].data;
                end
            end
        end
        // A new op overwrites everything and starts with redirect clear
        if (i_dispatch_en) begin
            entry_nxt.redirect = 1'b0;
            entry_nxt.op       = i_dispatch.op;
            entry_nxt.pc       = i_dispatch.pc;
            entry_nxt.rdst     = i_dispatch.rdst;
            entry_nxt.data     = i_dispatch.data;
        end
    end

    // Next state, dispatch overrides the case and flush overrides dispatch
    always_comb begin
        state_nxt = state_r;
        case (state_r)
            rob_pkg::ST_INVALID: begin
                state_nxt = rob_pkg::ST_INVALID;
            end
            rob_pkg::ST_PENDING: begin
                if (cdb_hit) begin
                    state_nxt = is_lsu_op ? rob_pkg::ST_LSU_PENDING : rob_pkg::ST_RETIRABLE;
                end
            end
            rob_pkg::ST_LSU_PENDING: begin
                if (ld_ack || st_ack) begin
                    state_nxt = rob_pkg::ST_RETIRABLE;
                end
            end
            rob_pkg::ST_RETIRABLE: begin
                if (i_retire_en) begin
                    state_nxt = rob_pkg::ST_INVALID;
                end
            end
            default: begin
                state_nxt = rob_pkg::ST_INVALID;
            end
        endcase
        if (i_dispatch_en) begin
            state_nxt = rob_pkg::ST_PENDING;
        end
        if (i_flush) begin
            state_nxt = rob_pkg::ST_INVALID;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_r <= rob_pkg::ST_INVALID;
        end else begin
            state_r <= state_nxt;
        end
    end

    always_ff @(posedge clk) begin
        entry_r <= entry_nxt;
    end

    assign o_retirable   = (state_r == rob_pkg::ST_RETIRABLE);
    assign o_lsu_pending = lsu_pending;
    assign o_entry       = entry_r;

endmodule

`default_nettype wire

// File: logic/rob_ptrs.sv
// Reorder buffer pointers
// Head and tail indices plus an occupancy count, so that a full buffer
// and an empty one can be told apart when the pointers are equal
`default_nettype none

module rob_ptrs (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_dispatch_en,
    input  logic                          i_retire_en,
    input  logic                          i_flush,
    output logic [rob_pkg::ROB_IDX_W-1:0] o_head,
    output logic [rob_pkg::ROB_IDX_W-1:0] o_tail,
    output logic                          o_full,
    output logic                          o_empty
);

    logic [rob_pkg::ROB_IDX_W-1:0] head_r;
    logic [rob_pkg::ROB_IDX_W-1:0] tail_r;
    // One bit wider than the index so it can hold ROB_DEPTH
    logic [rob_pkg::ROB_IDX_W:0]   count_r;
    logic [rob_pkg::ROB_IDX_W-1:0] head_inc;
    logic [rob_pkg::ROB_IDX_W-1:0] tail_inc;

    // Wrap explicitly so a depth that is not a power of two still works
    assign head_inc = (int'(head_r) == rob_pkg::ROB_DEPTH - 1) ? '0 : head_r + 1'b1;
    assign tail_inc = (int'(tail_r) == rob_pkg::ROB_DEPTH - 1) ? '0 : tail_r + 1'b1;

    always_ff @(posedge clk) begin
        if (i_reset || i_flush) begin
            head_r  <= '0;
            tail_r  <= '0;
            count_r <= '0;
        end else begin
            if (i_dispatch_en) begin
                tail_r <= tail_inc;
            end
            if (i_retire_en) begin
                head_r <= head_inc;
            end
            // Count only moves when exactly one side is active
            case ({i_dispatch_en, i_retire_en})
                2'b10: begin
                    count_r <= count_r + 1'b1;
                end
                2'b01: begin
                    count_r <= count_r - 1'b1;
                end
                default: begin
                    count_r <= count_r;
                end
            endcase
        end
    end

    assign o_head  = head_r;
    assign o_tail  = tail_r;
    assign o_full  = (int'(count_r) == rob_pkg::ROB_DEPTH);
    assign o_empty = (count_r == '0);

endmodule

`default_nettype wire

// File: logic/rob_retire.sv
// Reorder buffer retire stage
// Looks only at the head entry. Drives retire, redirect and the LSU
// requests, and steers the retire and acknowledge strobes back to the
// head slot as one-hot vectors
`default_nettype none

module rob_retire (
    input  logic [rob_pkg::ROB_IDX_W-1:0] i_head,
    input  logic [rob_pkg::ROB_DEPTH-1:0] i_retirable,
    input  logic [rob_pkg::ROB_DEPTH-1:0] i_lsu_pending,
    input  rob_pkg::entry_t               i_entries [0:rob_pkg::ROB_DEPTH-1],
    output logic [rob_pkg::ROB_DEPTH-1:0] o_retire_sel,
    output logic [rob_pkg::ROB_DEPTH-1:0] o_lsu_ack_sel,
    output logic                          o_retire_en,
    output rob_pkg::entry_t               o_retire,
    output logic                          o_redirect,
    output logic [rob_pkg::ADDR_W-1:0]    o_redirect_pc,
    output logic                          o_flush,
    output logic                          o_lsu_retire_ld,
    output logic                          o_lsu_retire_st
);

    logic [rob_pkg::ROB_DEPTH-1:0] head_onehot;
    rob_pkg::entry_t               head_entry;
    logic                          head_lsu_pending;

    // Decode the head index once and reuse it for both strobes
    assign head_onehot      = {{(rob_pkg::ROB_DEPTH-1){1'b0}}, 1'b1} << i_head;
    assign head_entry       = i_entries[i_head];
    assign head_lsu_pending = i_lsu_pending[i_head];

    // Retire whenever the head is complete, the consumer never stalls
    assign o_retire_en  = i_retirable[i_head];
    assign o_retire     = head_entry;
    assign o_retire_sel = o_retire_en ? head_onehot : '0;

    // The LSU acknowledge only goes to the head slot while it waits for it
    assign o_lsu_ack_sel = head_lsu_pending ? head_onehot : '0;

    // Ask the load queue or store queue to finish the head op
    assign o_lsu_retire_ld = head_lsu_pending && (head_entry.op == rob_pkg::OP_LD);
    assign o_lsu_retire_st = head_lsu_pending && (head_entry.op == rob_pkg::OP_ST);

    // A redirecting retire restarts fetch at the entry pc
    // and throws away everything younger
    assign o_redirect    = o_retire_en && head_entry.redirect;
    assign o_redirect_pc = head_entry.pc;
    assign o_flush       = o_redirect;

endmodule

`default_nettype wire

// File: logic/rob_top.sv
// Reorder buffer top level
// Builds the entry array, the head and tail pointers and the retire stage.
// Dispatch goes to the tail slot, retire and flush come from the head
`default_nettype none

module rob_top (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_dispatch_en,
    input  rob_pkg::dispatch_t            i_dispatch,
    output logic [rob_pkg::ROB_IDX_W-1:0] o_dispatch_tag,
    output logic                          o_full,
    input  rob_pkg::cdb_t                 i_cdb [0:rob_pkg::CDB_DEPTH-1],
    input  rob_pkg::lsu_ack_t             i_lsu_ack,
    output logic                          o_retire_en,
    output rob_pkg::entry_t               o_retire,
    output logic                          o_redirect,
    output logic [rob_pkg::ADDR_W-1:0]    o_redirect_pc,
    output logic                          o_lsu_retire_ld,
    output logic                          o_lsu_retire_st,
    output logic                          o_empty
);

    logic [rob_pkg::ROB_IDX_W-1:0] head;
    logic [rob_pkg::ROB_IDX_W-1:0] tail;
    logic                          flush;
    logic                          dispatch_accept;
    logic [rob_pkg::ROB_DEPTH-1:0] tail_onehot;
    logic [rob_pkg::ROB_DEPTH-1:0] retirable;
    logic [rob_pkg::ROB_DEPTH-1:0] lsu_pending;
    logic [rob_pkg::ROB_DEPTH-1:0] retire_sel;
    logic [rob_pkg::ROB_DEPTH-1:0] lsu_ack_sel;
    rob_pkg::entry_t               entries [0:rob_pkg::ROB_DEPTH-1];

    // A dispatch during a flush cycle is dropped, the tail resets anyway
    assign dispatch_accept = i_dispatch_en && !o_full && !flush;
    assign tail_onehot     = {{(rob_pkg::ROB_DEPTH-1){1'b0}}, 1'b1} << tail;
    assign o_dispatch_tag  = tail;

    rob_ptrs rob_ptrs_i (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_dispatch_en (dispatch_accept),
        .i_retire_en   (o_retire_en),
        .i_flush       (flush),
        .o_head        (head),
        .o_tail        (tail),
        .o_full        (o_full),
        .o_empty       (o_empty)
    );

    // Each slot knows its own index and matches result bus tags against it
    for (genvar i = 0; i < rob_pkg::ROB_DEPTH; i++) begin : g_entry
        rob_entry #(
            .ENTRY_TAG (i)
        ) rob_entry_i (
            .clk           (clk),
            .i_reset       (i_reset),
            .i_flush       (flush),
            .i_dispatch_en (dispatch_accept && tail_onehot[i]),
            .i_dispatch    (i_dispatch),
            .i_cdb         (i_cdb),
            .i_lsu_ack     (i_lsu_ack),
            .i_lsu_ack_sel (lsu_ack_sel[i]),
            .i_retire_en   (retire_sel[i]),
            .o_retirable   (retirable[i]),
            .o_lsu_pending (lsu_pending[i]),
            .o_entry       (entries[i])
        );
    end

    rob_retire rob_retire_i (
        .i_head          (head),
        .i_retirable     (retirable),
        .i_lsu_pending   (lsu_pending),
        .i_entries       (entries),
        .o_retire_sel    (retire_sel),
        .o_lsu_ack_sel   (lsu_ack_sel),
        .o_retire_en     (o_retire_en),
        .o_retire        (o_retire),
        .o_redirect      (o_redirect),
        .o_redirect_pc   (o_redirect_pc),
        .o_flush         (flush),
        .o_lsu_retire_ld (o_lsu_retire_ld),
        .o_lsu_retire_st (o_lsu_retire_st)
    );

endmodule

`default_nettype wire

// File: test/rob_asserts.sv
// Reorder buffer protocol assertions
// Bound into the top level to watch dispatch, retire, redirect and LSU requests
`default_nettype none

module rob_asserts (
    input logic clk,
    input logic i_reset,
    input logic i_dispatch_en,
    input logic i_full,
    input logic i_empty,
    input logic i_retire_en,
    input logic i_redirect,
    input logic i_lsu_retire_ld,
    input logic i_lsu_retire_st
);

    // Assertion failures seen so far
    int fail_count = 0;

    // The tail slot still holds a live op while the buffer is full
    no_dispatch_when_full: assert property (@(posedge clk) disable iff (i_reset)
        !(i_dispatch_en && i_full))
        else begin
            $error("dispatch while the buffer is full");
            fail_count++;
        end

    no_retire_when_empty: assert property (@(posedge clk) disable iff (i_reset)
        !(i_retire_en && i_empty))
        else begin
            $error("retire while the buffer is empty");
            fail_count++;
        end

    redirect_needs_retire: assert property (@(posedge clk) disable iff (i_reset)
        i_redirect |-> i_retire_en)
        else begin
            $error("redirect without a retire");
            fail_count++;
        end

    // Only the head op can ask the LSU, so at most one request at a time
    lsu_request_onehot: assert property (@(posedge clk) disable iff (i_reset)
        $onehot0({i_lsu_retire_ld, i_lsu_retire_st})
        && (!(i_lsu_retire_ld || i_lsu_retire_st) || !i_empty))
        else begin
            $error("LSU requests overlap or come from an empty buffer");
            fail_count++;
        end

endmodule

bind rob_top rob_asserts rob_asserts_i (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_dispatch_en   (i_dispatch_en),
    .i_full          (o_full),
    .i_empty         (o_empty),
    .i_retire_en     (o_retire_en),
    .i_redirect      (o_redirect),
    .i_lsu_retire_ld (o_lsu_retire_ld),
    .i_lsu_retire_st (o_lsu_retire_st)
);

`default_nettype wire

// File: test/rob_top_tb.sv
// Reorder buffer testbench
// Dispatches groups of ops from a table, completes them out of order on both
// result buses, answers LSU requests and checks every retire against a model
`default_nettype none

module rob_top_tb;

    typedef struct packed {
        rob_pkg::op_t op;
        logic [4:0]   rdst;
        logic         redirect;
        logic         missp;
        logic [2:0]   order;
    } row_t;

    localparam int N_ROWS   = 22;
    localparam int N_GROUPS = 5;
    localparam int GROUP_SIZE [0:N_GROUPS-1] = '{4, 4, 4, 2, 8};

    // Columns are op, rdst, result bus redirect, misspeculated, completion order
    localparam row_t ROWS [0:N_ROWS-1] = '{
        // Results arrive in reverse order
        '{rob_pkg::OP_ALU, 5'd1, 1'b0, 1'b0, 3'd3},
        '{rob_pkg::OP_BR,  5'd0, 1'b0, 1'b0, 3'd2},
        '{rob_pkg::OP_JL,  5'd2, 1'b0, 1'b0, 3'd1},
        '{rob_pkg::OP_ALU, 5'd3, 1'b0, 1'b0, 3'd0},
        // The second load is misspeculated and throws away the ALU op
        '{rob_pkg::OP_LD,  5'd4, 1'b0, 1'b0, 3'd1},
        '{rob_pkg::OP_ST,  5'd0, 1'b0, 1'b0, 3'd0},
        '{rob_pkg::OP_LD,  5'd5, 1'b0, 1'b1, 3'd2},
        '{rob_pkg::OP_ALU, 5'd6, 1'b0, 1'b0, 3'd3},
        // A taken branch redirects from the result bus
        '{rob_pkg::OP_ALU, 5'd7, 1'b0, 1'b0, 3'd2},
        '{rob_pkg::OP_BR,  5'd0, 1'b1, 1'b0, 3'd0},
        '{rob_pkg::OP_ALU, 5'd8, 1'b0, 1'b0, 3'd1},
        '{rob_pkg::OP_JL,  5'd9, 1'b0, 1'b0, 3'd3},
        // Two ops refill the slots in front of the completed ones the branch flushed
        '{rob_pkg::OP_ALU, 5'd16, 1'b0, 1'b0, 3'd1},
        '{rob_pkg::OP_LD,  5'd17, 1'b0, 1'b0, 3'd0},
        // Eight ops fill every slot before any result shows up
        '{rob_pkg::OP_ALU, 5'd10, 1'b0, 1'b0, 3'd7},
        '{rob_pkg::OP_LD,  5'd11, 1'b0, 1'b0, 3'd6},
        '{rob_pkg::OP_ST,  5'd0,  1'b0, 1'b0, 3'd5},
        '{rob_pkg::OP_JL,  5'd12, 1'b0, 1'b0, 3'd4},
        '{rob_pkg::OP_BR,  5'd0,  1'b0, 1'b0, 3'd3},
        '{rob_pkg::OP_ALU, 5'd13, 1'b0, 1'b0, 3'd2},
        '{rob_pkg::OP_LD,  5'd14, 1'b0, 1'b0, 3'd1},
        '{rob_pkg::OP_ALU, 5'd15, 1'b0, 1'b0, 3'd0}
    };

    logic                          clk;
    logic                          i_reset;
    logic                          i_dispatch_en;
    rob_pkg::dispatch_t            i_dispatch;
    logic [rob_pkg::ROB_IDX_W-1:0] o_dispatch_tag;
    logic                          o_full;
    rob_pkg::cdb_t                 i_cdb [0:rob_pkg::CDB_DEPTH-1];
    rob_pkg::lsu_ack_t             i_lsu_ack;
    logic                          o_retire_en;
    rob_pkg::entry_t               o_retire;
    logic                          o_redirect;
    logic [rob_pkg::ADDR_W-1:0]    o_redirect_pc;
    logic                          o_lsu_retire_ld;
    logic                          o_lsu_retire_st;
    logic                          o_empty;

    // Model of the buffer holding the ops still to retire in dispatch order
    logic [31:0]                   lcg_state = 32'h218b_c566;
    rob_pkg::entry_t               exp_q [$];
    int                            exp_tail = 0;
    int                            exp_count = 0;
    int                            acks_done = 0;
    logic [rob_pkg::ROB_IDX_W-1:0] row_tag [0:N_ROWS-1];
    logic [31:0]                   row_result [0:N_ROWS-1];

    rob_top rob_top_i (
        .clk             (clk),
        .i_reset         (i_reset),
        .i_dispatch_en   (i_dispatch_en),
        .i_dispatch      (i_dispatch),
        .o_dispatch_tag  (o_dispatch_tag),
        .o_full          (o_full),
        .i_cdb           (i_cdb),
        .i_lsu_ack       (i_lsu_ack),
        .o_retire_en     (o_retire_en),
        .o_retire        (o_retire),
        .o_redirect      (o_redirect),
        .o_redirect_pc   (o_redirect_pc),
        .o_lsu_retire_ld (o_lsu_retire_ld),
        .o_lsu_retire_st (o_lsu_retire_st),
        .o_empty         (o_empty)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // Every row gets far more cycles than it needs
    initial begin
        repeat (N_ROWS * 50) @(posedge clk);
        report_failure("Timeout, the buffer stopped retiring ops");
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] actual,
                         input logic [63:0] expected);
        if (actual !== expected) begin
            report_failure($sformatf("ERROR: %s is 0x%0h, expected 0x%0h",
                                     name, actual, expected));
        end
    endtask

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Writes one row at the tail and records what it must retire with
    task automatic dispatch_row(input int r);
        rob_pkg::entry_t want;
        logic [31:0]     pc;
        logic [31:0]     link;
        pc            = next_rand();
        link          = next_rand();
        row_result[r] = next_rand();
        i_dispatch    = '{op: ROWS[r].op, pc: pc, rdst: ROWS[r].rdst, data: link};
        i_dispatch_en = 1'b1;
        check("o_dispatch_tag", o_dispatch_tag, exp_tail);
        row_tag[r]    = o_dispatch_tag;
        // A load takes redirect from the acknowledge, others from the result bus
        want.redirect = (ROWS[r].op == rob_pkg::OP_LD) ? ROWS[r].missp : ROWS[r].redirect;
        want.op       = ROWS[r].op;
        want.rdst     = ROWS[r].rdst;
        // Jumps keep the link address and get their target from the result bus
        want.pc       = (ROWS[r].op == rob_pkg::OP_JL) ? row_result[r] : pc;
        want.data     = (ROWS[r].op == rob_pkg::OP_JL) ? link : row_result[r];
        exp_q.push_back(want);
        @(posedge clk);
        #2;
        i_dispatch_en = 1'b0;
        exp_tail      = (exp_tail + 1) % rob_pkg::ROB_DEPTH;
        exp_count++;
    endtask

    // Two completions per cycle with bus 0 taking the even order and bus 1 the odd one
    task automatic complete_group(input int first, input int size);
        for (int p = 0; p < size; p += rob_pkg::CDB_DEPTH) begin
            for (int b = 0; b < rob_pkg::CDB_DEPTH; b++) begin
                for (int r = first; r < first + size; r++) begin
                    if (int'(ROWS[r].order) == p + b) begin
                        i_cdb[b] = '{en: 1'b1, redirect: ROWS[r].redirect,
                                     tag: row_tag[r], data: row_result[r]};
                    end
                end
            end
            @(posedge clk);
            #2;
            for (int b = 0; b < rob_pkg::CDB_DEPTH; b++) begin
                i_cdb[b] = '0;
            end
        end
    endtask

    // Retire monitor that checks the flags against the model count before updating it
    initial begin
        rob_pkg::entry_t want;
        forever begin
            @(negedge clk);
            if (!i_reset) begin
                check("o_full", o_full, exp_count == rob_pkg::ROB_DEPTH);
                check("o_empty", o_empty, exp_count == 0);
                if (o_retire_en) begin
                    if (exp_q.size() == 0) begin
                        report_failure("An op retired although none was outstanding");
                    end
                    want = exp_q.pop_front();
                    check("o_retire.op", o_retire.op, want.op);
                    check("o_retire.rdst", o_retire.rdst, want.rdst);
                    check("o_retire.pc", o_retire.pc, want.pc);
                    check("o_retire.data", o_retire.data, want.data);
                    check("o_retire.redirect", o_retire.redirect, want.redirect);
                    check("o_redirect", o_redirect, want.redirect);
                    if (want.op == rob_pkg::OP_LD || want.op == rob_pkg::OP_ST) begin
                        if (acks_done == 0) begin
                            report_failure("A load or store retired before its acknowledge");
                        end
                        acks_done--;
                    end
                    // A redirect empties the whole buffer and restarts the tail at zero
                    if (want.redirect) begin
                        check("o_redirect_pc", o_redirect_pc, want.pc);
                        exp_q.delete();
                        exp_count = 0;
                        exp_tail  = 0;
                    end else begin
                        exp_count--;
                    end
                end
            end
        end
    end

    // LSU model that acknowledges the head load or store one cycle after the request
    initial begin
        logic ld;
        logic st;
        logic missp;
        forever begin
            @(negedge clk);
            if (!i_reset && (o_lsu_retire_ld || o_lsu_retire_st)) begin
                if (exp_q.size() == 0) begin
                    report_failure("LSU request while no op was outstanding");
                end
                ld    = (exp_q[0].op == rob_pkg::OP_LD);
                st    = (exp_q[0].op == rob_pkg::OP_ST);
                missp = exp_q[0].redirect;
                check("o_lsu_retire_ld", o_lsu_retire_ld, ld);
                check("o_lsu_retire_st", o_lsu_retire_st, st);
                @(posedge clk);
                #2;
                i_lsu_ack = '{lq_ack: ld, sq_ack: st, misspeculated: ld && missp};
                @(posedge clk);
                #2;
                i_lsu_ack = '0;
                acks_done++;
            end
        end
    end

    initial begin
        int first;
        i_reset       = 1'b1;
        i_dispatch_en = 1'b0;
        i_dispatch    = '0;
        i_lsu_ack     = '0;
        for (int b = 0; b < rob_pkg::CDB_DEPTH; b++) begin
            i_cdb[b] = '0;
        end
        first = 0;
        repeat (10) @(posedge clk);
        #2;
        i_reset = 1'b0;
        @(negedge clk);
        check("o_retire_en", o_retire_en, 1'b0);
        check("o_redirect", o_redirect, 1'b0);
        check("o_lsu_retire_ld", o_lsu_retire_ld, 1'b0);
        check("o_lsu_retire_st", o_lsu_retire_st, 1'b0);
        @(posedge clk);
        #2;
        for (int g = 0; g < N_GROUPS; g++) begin
            for (int i = 0; i < GROUP_SIZE[g]; i++) begin
                dispatch_row(first + i);
            end
            if (GROUP_SIZE[g] == rob_pkg::ROB_DEPTH) begin
                check("o_full", o_full, 1'b1);
            end
            complete_group(first, GROUP_SIZE[g]);
            while (!o_empty) begin
                @(negedge clk);
            end
            check("ops left to retire", exp_q.size(), 0);
            check("unused LSU acknowledges", acks_done, 0);
            @(posedge clk);
            #2;
            first += GROUP_SIZE[g];
        end
        if (rob_top_i.rob_asserts_i.fail_count != 0) begin
            report_failure("A protocol assertion on the buffer failed");
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: rob_top.f
logic/rob_pkg.sv
logic/rob_entry.sv
logic/rob_ptrs.sv
logic/rob_retire.sv
logic/rob_top.sv
test/rob_asserts.sv
test/rob_top_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := rob_top_tb
FILELIST  := rob_top.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
